// File: hw/array_drive_settings.svh
`ifndef ARRAY_DRIVE_SETTINGS_SVH
`define ARRAY_DRIVE_SETTINGS_SVH

// Array size.
`define ARRAY_DEPTH 8
`define DRIVE_ADDR_W 3

// Modulation table.
`define MOD_DEPTH 16
`define MOD_ADDR_W 4

// Encoder table, indexed by a full intensity.
`define PWE_ADDR_W 8

`endif

// File: hw/array_drive_pkg.sv
`default_nettype none

package array_drive_pkg;

  typedef enum logic [1:0] {
    SEL_DRIVE = 2'd0,
    SEL_MOD   = 2'd1,
    SEL_PWE   = 2'd2
  } table_sel_t;

  typedef struct packed {
    logic        en;
    table_sel_t  sel;
    logic [7:0]  addr;
    logic [15:0] data;  // Low bits hold the entry.
  } host_wr_t;

  typedef struct packed {
    logic [7:0] intensity;
    logic [7:0] phase;
  } drive_t;

  typedef logic [7:0] mod_t;
  typedef logic [7:0] pw_t;

  typedef struct packed {
    logic       valid;
    logic [7:0] intensity;
    logic [7:0] phase;
  } beat_t;

  typedef struct packed {
    logic       valid;
    pw_t        pulse_width;
    logic [7:0] phase;
  } pw_beat_t;

endpackage

`default_nettype wire

// File: hw/table_ram.sv
`timescale 1ns/1ps
`default_nettype none

module table_ram #(
  parameter type entry_t = logic [7:0],
  parameter int ADDR_W = 8,
  parameter array_drive_pkg::table_sel_t TABLE_SEL = array_drive_pkg::SEL_DRIVE
) (
  input  logic                      clk,
  input  array_drive_pkg::host_wr_t host_wr,
  input  logic [ADDR_W-1:0]         rd_addr,
  output entry_t                    rd_data
);

  localparam int DEPTH = 2 ** ADDR_W;
  localparam int ENTRY_W = $bits(entry_t);

  entry_t mem [DEPTH];
  logic   wr_hit;
  logic [ADDR_W-1:0] wr_addr;

  assign wr_hit = host_wr.en && (host_wr.sel == TABLE_SEL);
  assign wr_addr = host_wr.addr[ADDR_W-1:0];  // Upper bits alias.

  always_ff @(posedge clk) begin
    if (wr_hit) begin
      mem[wr_addr] <= entry_t'(host_wr.data[ENTRY_W-1:0]);
    end
  end

  // One cycle read latency.
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

`default_nettype wire

// File: hw/time_cnt_generator.sv
`timescale 1ns/1ps
`default_nettype none

module time_cnt_generator (
  input  logic       clk,
  input  logic       arst_n,
  output logic [7:0] time_cnt,
  output logic       update
);

  localparam logic [7:0] PRE_LAST = 8'd254;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      time_cnt <= 8'd0;
    end else begin
      time_cnt <= time_cnt + 8'd1;  // Wraps at 256.
    end
  end

  // Registered so the pulse sits on count 255.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      update <= 1'b0;
    end else begin
      update <= (time_cnt == PRE_LAST);
    end
  end

endmodule

`default_nettype wire

// File: hw/drive_source.sv
`timescale 1ns/1ps
`default_nettype none
`include "array_drive_settings.svh"

module drive_source (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic                       update,
  output logic [`DRIVE_ADDR_W-1:0]   rd_addr,
  input  array_drive_pkg::drive_t    rd_data,
  output array_drive_pkg::beat_t     dout
);

  localparam int ADDR_W = `DRIVE_ADDR_W;
  localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(`ARRAY_DEPTH - 1);

  logic busy;
  logic rd_valid;

  ////////////////////
  // Address sweep
  ////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      busy    <= 1'b0;
      rd_addr <= '0;
    end else if (update) begin
      busy    <= 1'b1;
      rd_addr <= '0;
    end else if (busy) begin
      rd_addr <= rd_addr + 1'b1;
      if (rd_addr == LAST_ADDR) begin
        busy <= 1'b0;  // Last transducer issued.
      end
    end
  end

  // Valid follows the read by one cycle.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= busy;
    end
  end

  assign dout.valid = rd_valid;
  assign dout.intensity = rd_data.intensity;
  assign dout.phase = rd_data.phase;

endmodule

`default_nettype wire

// File: hw/modulation.sv
`timescale 1ns/1ps
`default_nettype none
`include "array_drive_settings.svh"

module modulation (
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic                      update,
  input  array_drive_pkg::beat_t    din,
  output array_drive_pkg::beat_t    dout,
  output logic [`MOD_ADDR_W-1:0]    rd_addr,
  input  array_drive_pkg::mod_t     rd_data
);

  localparam int ADDR_W = `MOD_ADDR_W;
  localparam logic [ADDR_W-1:0] LAST_IDX = ADDR_W'(`MOD_DEPTH - 1);

  logic [ADDR_W-1:0]     mod_idx;
  logic                  upd_q;
  array_drive_pkg::mod_t mod_val;
  logic [8:0]            mod_scale;
  logic [15:0]           product;
  logic                  valid_q;
  logic [7:0]            intensity_q;
  logic [7:0]            phase_q;

  assign rd_addr = mod_idx;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mod_idx <= '0;
      upd_q   <= 1'b0;
      valid_q <= 1'b0;
    end else begin
      upd_q   <= update;
      valid_q <= din.valid;
      if (update) begin
        mod_idx <= (mod_idx == LAST_IDX) ? '0 : mod_idx + 1'b1;
      end
    end
  end

  // Held for the whole period.
  always_ff @(posedge clk) begin
    if (upd_q) begin
      mod_val <= rd_data;
    end
  end

  assign mod_scale = {1'b0, mod_val} + 9'd1;
  assign product = din.intensity * mod_scale;  // At most 255 * 256.

  always_ff @(posedge clk) begin
    intensity_q <= product[15:8];
    phase_q     <= din.phase;
  end

  assign dout.valid = valid_q;
  assign dout.intensity = intensity_q;
  assign dout.phase = phase_q;

endmodule

`default_nettype wire

// File: hw/pulse_width_encoder.sv
`timescale 1ns/1ps
`default_nettype none
`include "array_drive_settings.svh"

module pulse_width_encoder (
  input  logic                       clk,
  input  logic                       arst_n,
  input  array_drive_pkg::beat_t     din,
  output array_drive_pkg::pw_beat_t  dout,
  output logic [`PWE_ADDR_W-1:0]     rd_addr,
  input  array_drive_pkg::pw_t       rd_data
);

  logic       valid_q;
  logic [7:0] phase_q;

  assign rd_addr = din.intensity;  // Table read in flight.

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= din.valid;
    end
  end

  always_ff @(posedge clk) begin
    phase_q <= din.phase;
  end

  // Pair delayed phase with the returned width.
  assign dout.valid = valid_q;
  assign dout.pulse_width = rd_data;
  assign dout.phase = phase_q;

endmodule

`default_nettype wire

// File: hw/pwm.sv
`timescale 1ns/1ps
`default_nettype none
`include "array_drive_settings.svh"

module pwm (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic [7:0]                 time_cnt,
  input  logic                       update,
  input  array_drive_pkg::pw_beat_t  din,
  output logic [`ARRAY_DEPTH-1:0]    pwm_out
);

  localparam int N = `ARRAY_DEPTH;
  localparam int IDX_W = `DRIVE_ADDR_W;

  logic [IDX_W-1:0]     beat_idx;
  array_drive_pkg::pw_t sh_pw  [N];
  logic [7:0]           sh_ph  [N];
  array_drive_pkg::pw_t act_pw [N];
  logic [7:0]           act_ph [N];
  logic [7:0]           elapsed [N];

  ////////////////////
  // Shadow capture
  ////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      beat_idx <= '0;
    end else if (update) begin
      beat_idx <= '0;
    end else if (din.valid) begin
      beat_idx <= beat_idx + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (din.valid) begin
      sh_pw[beat_idx] <= din.pulse_width;  // Arrival order.
      sh_ph[beat_idx] <= din.phase;
    end
  end

  ////////////////////
  // Active set, output
  ////////////////////

  always_comb begin
    for (int i = 0; i < N; i++) begin
      elapsed[i] = time_cnt - act_ph[i];  // Modulo 256.
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < N; i++) begin
        act_pw[i] <= '0;
        act_ph[i] <= '0;
      end
      pwm_out <= '0;
    end else begin
      if (update) begin
        for (int i = 0; i < N; i++) begin
          act_pw[i] <= sh_pw[i];
          act_ph[i] <= sh_ph[i];
        end
      end
      for (int i = 0; i < N; i++) begin
        pwm_out[i] <= (elapsed[i] < act_pw[i]);
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/array_drive.sv
`timescale 1ns/1ps
`default_nettype none
`include "array_drive_settings.svh"

module array_drive (
  input  logic                       clk,
  input  logic                       arst_n,
  input  array_drive_pkg::host_wr_t  host_wr,
  output logic [`ARRAY_DEPTH-1:0]    pwm_out
);

  logic [7:0] time_cnt;
  logic       update;

  logic [`DRIVE_ADDR_W-1:0] drive_addr;
  logic [`MOD_ADDR_W-1:0]   mod_addr;
  logic [`PWE_ADDR_W-1:0]   pwe_addr;

  array_drive_pkg::drive_t   drive_data;
  array_drive_pkg::mod_t     mod_data;
  array_drive_pkg::pw_t      pwe_data;

  array_drive_pkg::beat_t    src_beat;
  array_drive_pkg::beat_t    mod_beat;
  array_drive_pkg::pw_beat_t pw_beat;

  ////////////////////
  // Lookup tables
  ////////////////////

  table_ram #(
    .entry_t(array_drive_pkg::drive_t),
    .ADDR_W(`DRIVE_ADDR_W),
    .TABLE_SEL(array_drive_pkg::SEL_DRIVE)
  ) drive_table (
    .clk(clk),
    .host_wr(host_wr),
    .rd_addr(drive_addr),
    .rd_data(drive_data)
  );

  table_ram #(
    .entry_t(array_drive_pkg::mod_t),
    .ADDR_W(`MOD_ADDR_W),
    .TABLE_SEL(array_drive_pkg::SEL_MOD)
  ) mod_table (
    .clk(clk),
    .host_wr(host_wr),
    .rd_addr(mod_addr),
    .rd_data(mod_data)
  );

  table_ram #(
    .entry_t(array_drive_pkg::pw_t),
    .ADDR_W(`PWE_ADDR_W),
    .TABLE_SEL(array_drive_pkg::SEL_PWE)
  ) pwe_table (
    .clk(clk),
    .host_wr(host_wr),
    .rd_addr(pwe_addr),
    .rd_data(pwe_data)
  );

  ////////////////////
  // Drive pipeline
  ////////////////////

  time_cnt_generator time_cnt_generator (
    .clk(clk),
    .arst_n(arst_n),
    .time_cnt(time_cnt),
    .update(update)
  );

  drive_source drive_source (
    .clk(clk),
    .arst_n(arst_n),
    .update(update),
    .rd_addr(drive_addr),
    .rd_data(drive_data),
    .dout(src_beat)
  );

  modulation modulation (
    .clk(clk),
    .arst_n(arst_n),
    .update(update),
    .din(src_beat),
    .dout(mod_beat),
    .rd_addr(mod_addr),
    .rd_data(mod_data)
  );

  pulse_width_encoder pulse_width_encoder (
    .clk(clk),
    .arst_n(arst_n),
    .din(mod_beat),
    .dout(pw_beat),
    .rd_addr(pwe_addr),
    .rd_data(pwe_data)
  );

  pwm pwm (
    .clk(clk),
    .arst_n(arst_n),
    .time_cnt(time_cnt),
    .update(update),
    .din(pw_beat),
    .pwm_out(pwm_out)
  );

endmodule

`default_nettype wire

// File: testbench/array_drive_props.sv
`timescale 1ns/1ps
`default_nettype none
`include "array_drive_settings.svh"

module array_drive_props (
  input logic                       clk,
  input logic                       arst_n,
  input logic                       update,
  input logic [`ARRAY_DEPTH-1:0]    pwm_out,
  input array_drive_pkg::pw_beat_t  pw_beat
);

  int fail_cnt;

  initial fail_cnt = 0;

  update_single: assert property (@(posedge clk) disable iff (!arst_n) update |=> !update)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("update high for more than one cycle");
    end

  update_period: assert property (@(posedge clk) disable iff (!arst_n) update |-> ##256 update)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("update did not recur after 256 cycles");
    end

  out_known: assert property (@(posedge clk) disable iff (!arst_n) !$isunknown(pwm_out))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("pwm_out has unknown bits");
    end

  // Beats must be clear of the shadow copy.
  beat_clear: assert property (@(posedge clk) disable iff (!arst_n) update |-> !pw_beat.valid)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("pwm beat valid during update");
    end

endmodule

bind array_drive array_drive_props props_i (
  .clk(clk),
  .arst_n(arst_n),
  .update(update),
  .pwm_out(pwm_out),
  .pw_beat(pw_beat)
);

`default_nettype wire

// File: testbench/array_drive_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "array_drive_settings.svh"

module array_drive_tb;

  localparam int N = `ARRAY_DEPTH;
  localparam int MD = `MOD_DEPTH;
  localparam int PERIOD = 256;
  localparam int NUM_TESTS = 6;
  localparam longint LIMIT_NS = (NUM_TESTS * 12 + 20) * PERIOD * 4;  // Plus margin.

  logic                      clk;
  logic                      arst_n;
  array_drive_pkg::host_wr_t host_wr;
  logic [N-1:0]              pwm_out;

  logic [7:0]   drv_int [N];
  logic [7:0]   drv_ph  [N];
  logic [7:0]   mod_tab [MD];
  logic [7:0]   pwe_tab [PERIOD];
  logic [255:0] wave    [N];
  int           high_cnt [N];
  int           rise_at  [N];
  int           errors;
  int           tests_run;
  int           tests_failed;
  int           err_at_start;

  array_drive dut_i (
    .clk(clk),
    .arst_n(arst_n),
    .host_wr(host_wr),
    .pwm_out(pwm_out)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    #(LIMIT_NS);
    $display("Timeout: the tests did not finish within %0d ns", LIMIT_NS);
    $display("Done: errors found");
    $finish;
  end

  ////////////////////
  // Table loading
  ////////////////////

  task automatic write_table(input array_drive_pkg::table_sel_t sel, input int addr,
                             input logic [15:0] data);
    array_drive_pkg::host_wr_t wr;
    wr.en = 1'b1;
    wr.sel = sel;
    wr.addr = addr[7:0];
    wr.data = data;
    @(posedge clk);
    host_wr <= wr;
  endtask

  task automatic load_patterns();
    for (int i = 0; i < N; i++) begin
      write_table(array_drive_pkg::SEL_DRIVE, i, {drv_int[i], drv_ph[i]});
    end
    for (int k = 0; k < MD; k++) begin
      write_table(array_drive_pkg::SEL_MOD, k, {8'd0, mod_tab[k]});
    end
    for (int k = 0; k < PERIOD; k++) begin
      write_table(array_drive_pkg::SEL_PWE, k, {8'd0, pwe_tab[k]});
    end
    @(posedge clk);
    host_wr <= '0;
  endtask

  task automatic identity_encoder();
    for (int k = 0; k < PERIOD; k++) begin
      pwe_tab[k] = k[7:0];
    end
  endtask

  task automatic full_modulation();
    for (int k = 0; k < MD; k++) begin
      mod_tab[k] = 8'd255;  // Scale of 256, intensity unchanged.
    end
  endtask

  ////////////////////
  // Sampling, model
  ////////////////////

  task automatic wait_update();
    @(negedge clk);
    while (dut_i.update !== 1'b1) begin
      @(negedge clk);
    end
  endtask

  // Window starts one cycle after the period, as pwm_out is registered.
  task automatic align_window();
    wait_update();
    @(negedge clk);
  endtask

  task automatic settle();
    repeat (3) wait_update();
    align_window();
  endtask

  task automatic sample_window();
    for (int s = 0; s < PERIOD; s++) begin
      @(negedge clk);
      for (int i = 0; i < N; i++) begin
        wave[i][s] = pwm_out[i];
      end
    end
    for (int i = 0; i < N; i++) begin
      high_cnt[i] = 0;
      rise_at[i] = -1;
      for (int s = 0; s < PERIOD; s++) begin
        if (wave[i][s]) high_cnt[i]++;
        if (wave[i][s] && !wave[i][(s + PERIOD - 1) % PERIOD] && rise_at[i] < 0) rise_at[i] = s;
      end
    end
  endtask

  function automatic int expected_pw(input int i, input int modv);
    int scaled;
    scaled = (drv_int[i] * (modv + 1)) >> 8;
    return pwe_tab[scaled];
  endfunction

  task automatic check_duty(input int modv);
    int exp_pw;
    for (int i = 0; i < N; i++) begin
      exp_pw = expected_pw(i, modv);
      assert (high_cnt[i] == exp_pw) else begin
        $display("FAILED t=%0t pwm_out[%0d] high count: got %0d, expected %0d",
                 $time, i, high_cnt[i], exp_pw);
        errors++;
      end
    end
  endtask

  task automatic check_offsets(input int modv);
    int pw0;
    int pwi;
    int exp_off;
    int got_off;
    pw0 = expected_pw(0, modv);
    for (int i = 1; i < N; i++) begin
      pwi = expected_pw(i, modv);
      if (pw0 > 0 && pwi > 0) begin  // A zero width has no edge.
        exp_off = (drv_ph[i] - drv_ph[0] + PERIOD) % PERIOD;
        got_off = (rise_at[i] - rise_at[0] + PERIOD) % PERIOD;
        assert (got_off == exp_off) else begin
          $display("FAILED t=%0t pwm_out[%0d] rising offset: got %0d, expected %0d",
                   $time, i, got_off, exp_off);
          errors++;
        end
      end
    end
  endtask

  task automatic start_test();
    err_at_start = errors;
    tests_run++;
  endtask

  task automatic finish_test(input string name);
    if (errors == err_at_start) begin
      $display("test %0d %s: pass", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: fail, %0d errors", tests_run, name, errors - err_at_start);
    end
  endtask

  ////////////////////
  // Directed tests
  ////////////////////

  task automatic reset_idle();
    start_test();
    align_window();
    repeat (2) begin
      sample_window();
      for (int i = 0; i < N; i++) begin
        assert (high_cnt[i] == 0) else begin
          $display("FAILED t=%0t pwm_out[%0d] high count: got %0d, expected 0",
                   $time, i, high_cnt[i]);
          errors++;
        end
      end
    end
    finish_test("reset_idle");
  endtask

  task automatic linear_duty();
    start_test();
    identity_encoder();
    full_modulation();
    for (int i = 0; i < N; i++) begin
      drv_int[i] = 8'(10 + 30 * i);
      drv_ph[i] = 8'(10 * i);
    end
    load_patterns();
    settle();
    sample_window();
    check_duty(255);
    finish_test("linear_duty");
  endtask

  task automatic phase_offsets();
    start_test();
    identity_encoder();
    full_modulation();
    for (int i = 0; i < N; i++) begin
      drv_int[i] = 8'd100;
      drv_ph[i] = 8'(3 + 29 * i);
    end
    load_patterns();
    settle();
    sample_window();
    check_duty(255);
    check_offsets(255);
    finish_test("phase_offsets");
  endtask

  task automatic nonlinear_encoder();
    start_test();
    full_modulation();
    for (int k = 0; k < PERIOD; k++) begin
      pwe_tab[k] = 8'((k * k) >> 8);  // Square law.
    end
    drv_int = '{8'd16, 8'd40, 8'd80, 8'd120, 8'd160, 8'd200, 8'd230, 8'd255};
    for (int i = 0; i < N; i++) begin
      drv_ph[i] = 8'(i * 32);
    end
    load_patterns();
    settle();
    sample_window();
    check_duty(255);
    finish_test("nonlinear_encoder");
  endtask

  task automatic mod_rotation();
    int obs [2*MD];
    int exp_seq [MD];
    bit found;
    bit match;
    start_test();
    identity_encoder();
    for (int k = 0; k < MD; k++) begin
      mod_tab[k] = 8'(16 * k + 7);
    end
    for (int i = 0; i < N; i++) begin
      drv_int[i] = 8'(200 - 5 * i);
      drv_ph[i] = 8'd0;
    end
    load_patterns();
    settle();
    for (int p = 0; p < 2 * MD; p++) begin
      sample_window();
      obs[p] = high_cnt[0];
    end
    for (int k = 0; k < MD; k++) begin
      exp_seq[k] = expected_pw(0, mod_tab[k]);
    end
    found = 1'b0;
    for (int r = 0; r < MD; r++) begin
      match = 1'b1;
      for (int p = 0; p < 2 * MD; p++) begin
        if (obs[p] != exp_seq[(p + r) % MD]) match = 1'b0;
      end
      if (match) found = 1'b1;
    end
    assert (found) else begin
      $display("pwm_out[0] duty over %0d periods is no rotation of the modulation sequence",
               2 * MD);
      errors++;
    end
    finish_test("mod_rotation");
  endtask

  task automatic random_pattern();
    start_test();
    identity_encoder();
    full_modulation();
    for (int i = 0; i < N; i++) begin
      drv_int[i] = 8'(1 + $urandom % 254);
      drv_ph[i] = 8'($urandom % 256);
    end
    load_patterns();
    settle();
    sample_window();
    check_duty(255);
    check_offsets(255);
    finish_test("random_pattern");
  endtask

  initial begin
    void'($urandom(26));
    host_wr = '0;
    arst_n = 1'b0;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    err_at_start = 0;
    repeat (10) @(posedge clk);
    arst_n <= 1'b1;
    reset_idle();
    linear_duty();
    phase_offsets();
    nonlinear_encoder();
    mod_rotation();
    random_pattern();
    $display("tests run %0d, failed %0d, check errors %0d, assertion failures %0d",
             tests_run, tests_failed, errors, dut_i.props_i.fail_cnt);
    if (errors == 0 && dut_i.props_i.fail_cnt == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
+incdir+hw
hw/array_drive_pkg.sv
hw/table_ram.sv
hw/time_cnt_generator.sv
hw/drive_source.sv
hw/modulation.sv
hw/pulse_width_encoder.sv
hw/pwm.sv
hw/array_drive.sv
testbench/array_drive_props.sv
testbench/array_drive_tb.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f list.f \
		--top-module array_drive_tb -o array_drive_sim
	./obj_dir/array_drive_sim +verilator+error+limit+1000 > sim.log 2>&1 || true
	@cat sim.log
	@grep -q "^Done: no errors$$" sim.log

clean:
	rm -rf obj_dir sim.log
